//--- csr_arch_pkg.sv
`default_nettype none

package csr_arch_pkg;

    // **************************************************
    // Machine-mode CSR addresses
    // **************************************************

    localparam logic [11:0] addr_mstatus   = 12'h300;
    localparam logic [11:0] addr_mtvec     = 12'h305;
    localparam logic [11:0] addr_mepc      = 12'h341;
    localparam logic [11:0] addr_mcause    = 12'h342;

    // **************************************************
    // mstatus fields
    // **************************************************

    localparam int          mstatus_mie    = 3;
    localparam int          mstatus_mpie   = 7;
    localparam int          mstatus_mpp_lo = 11;
    localparam int          mstatus_mpp_hi = 12;

    // Only MIE and MPIE can be written by software
    localparam logic [31:0] mstatus_wmask  = (32'h1 << mstatus_mie)
                                           | (32'h1 << mstatus_mpie);

    localparam logic [31:0] mstatus_reset  = 32'h0000_1800;    // MPP = 11 for machine mode

    // **************************************************
    // Exception causes
    // **************************************************

    localparam logic [31:0] cause_ecall_m  = 32'd11;           // Environment call from M-mode

endpackage

`default_nettype wire

//--- csr_bus_pkg.sv
`default_nettype none

package csr_bus_pkg;

    typedef enum logic [2:0] {
        csr_none,
        csr_rw,
        csr_rs,
        csr_rc,
        csr_ecall,
        csr_mret
    } csr_op_e;

    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;                                    // rs1 value
        logic [31:0] pc;
    } csr_req_t;

    typedef enum logic [1:0] {
        sel_mstatus,
        sel_mtvec,
        sel_mepc,
        sel_mcause
    } csr_sel_e;

    typedef struct packed {
        logic        en;
        csr_sel_e    sel;
        logic [31:0] data;                                     // Unmasked new value
    } csr_wr_t;

    typedef struct packed {
        logic [31:0] mstatus;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [31:0] mcause;
    } csr_state_t;

    typedef struct packed {
        logic        take;                                     // ecall
        logic        ret;                                      // mret
        logic [31:0] epc;
        logic [31:0] cause;
    } trap_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirect_t;

endpackage

`default_nettype wire

//--- csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access (
    input  wire csr_bus_pkg::csr_req_t   req,
    input  wire csr_bus_pkg::csr_state_t state,
    output csr_bus_pkg::csr_wr_t         wr,
    output logic [31:0]                  rdata,
    output logic                         illegal
);

    import csr_arch_pkg::*;
    import csr_bus_pkg::*;

    csr_sel_e    sel;
    logic        hit;                                          // Address names a known CSR
    logic        is_csr_op;
    logic [31:0] old_val;
    logic [31:0] new_val;

    // **************************************************
    // Address decode
    // **************************************************

    always_comb begin
        hit = 1'b1;
        sel = sel_mstatus;
        case (req.addr)
            addr_mstatus: sel = sel_mstatus;
            addr_mtvec:   sel = sel_mtvec;
            addr_mepc:    sel = sel_mepc;
            addr_mcause:  sel = sel_mcause;
            default:      hit = 1'b0;
        endcase
    end

    assign is_csr_op = (req.op == csr_rw) || (req.op == csr_rs) || (req.op == csr_rc);

    always_comb begin
        case (sel)
            sel_mstatus: old_val = state.mstatus;
            sel_mtvec:   old_val = state.mtvec;
            sel_mepc:    old_val = state.mepc;
            default:     old_val = state.mcause;
        endcase
    end

    // rs and rc write even when rs1 is zero
    always_comb begin
        case (req.op)
            csr_rs:  new_val = old_val | req.wdata;
            csr_rc:  new_val = old_val & ~req.wdata;
            default: new_val = req.wdata;                      // csrrw
        endcase
    end

    assign rdata    = (is_csr_op && hit) ? old_val : 32'h0;
    assign illegal  = is_csr_op && !hit;
    assign wr.en    = is_csr_op && hit;
    assign wr.sel   = sel;
    assign wr.data  = new_val;                                 // Masking is done in csr_file

endmodule

`default_nettype wire

//--- trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl (
    input  wire csr_bus_pkg::csr_req_t   req,
    input  wire csr_bus_pkg::csr_state_t state,
    output csr_bus_pkg::trap_wr_t        trap_wr,
    output csr_bus_pkg::redirect_t       redirect
);

    import csr_arch_pkg::*;
    import csr_bus_pkg::*;

    logic is_ecall;
    logic is_mret;

    assign is_ecall = (req.op == csr_ecall);
    assign is_mret  = (req.op == csr_mret);

    // **************************************************
    // Trap register update
    // **************************************************

    always_comb begin
        trap_wr.take  = is_ecall;
        trap_wr.ret   = is_mret;
        trap_wr.epc   = {req.pc[31:2], 2'b00};                 // Word aligned pc
        trap_wr.cause = cause_ecall_m;
    end

    // **************************************************
    // PC redirect
    // **************************************************

    always_comb begin
        redirect.valid = is_ecall || is_mret;
        if (is_mret) begin
            redirect.target = state.mepc;                      // Return to saved pc
        end else begin
            redirect.target = state.mtvec;                     // Direct mode handler
        end
    end

    // mtvec and mepc are stored aligned, so every redirect lands on a word
    always_comb begin
        if (redirect.valid) begin
            assert final (redirect.target[1:0] == 2'b00)
                else $error("trap_ctrl: misaligned redirect target %h", redirect.target);
        end
    end

endmodule

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
    parameter logic [31:0] mtvec_reset = 32'h0
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire csr_bus_pkg::csr_wr_t    wr,
    input  wire csr_bus_pkg::trap_wr_t   trap_wr,
    output csr_bus_pkg::csr_state_t      state
);

    import csr_arch_pkg::*;
    import csr_bus_pkg::*;

    logic [31:0] mstatus_wr;                                   // Masked software write
    logic [31:0] mstatus_take;                                 // State after ecall
    logic [31:0] mstatus_ret;                                  // State after mret

    // **************************************************
    // mstatus transitions
    // **************************************************

    always_comb begin
        mstatus_wr = (state.mstatus & ~mstatus_wmask) | (wr.data & mstatus_wmask);

        mstatus_take               = state.mstatus;
        mstatus_take[mstatus_mpie] = state.mstatus[mstatus_mie];
        mstatus_take[mstatus_mie]  = 1'b0;                     // Interrupts off in handler

        mstatus_ret                = state.mstatus;
        mstatus_ret[mstatus_mie]   = state.mstatus[mstatus_mpie];
        mstatus_ret[mstatus_mpie]  = 1'b1;
    end

    // **************************************************
    // Registers
    // **************************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state.mstatus <= mstatus_reset;
            state.mtvec   <= mtvec_reset;
            state.mepc    <= 32'h0;
            state.mcause  <= 32'h0;
        end else if (trap_wr.take) begin
            state.mstatus <= mstatus_take;
            state.mepc    <= trap_wr.epc;
            state.mcause  <= trap_wr.cause;
        end else if (trap_wr.ret) begin
            state.mstatus <= mstatus_ret;
        end else if (wr.en) begin
            case (wr.sel)
                sel_mstatus: state.mstatus <= mstatus_wr;
                sel_mtvec:   state.mtvec   <= {wr.data[31:2], 2'b00};    // Direct mode only
                sel_mepc:    state.mepc    <= {wr.data[31:2], 2'b00};
                default:     state.mcause  <= wr.data;
            endcase
        end
    end

    // One request per cycle keeps the two write ports apart
    assert property (@(posedge clk) disable iff (!rst_n)
        !(wr.en && (trap_wr.take || trap_wr.ret)))
        else $error("csr_file: CSR write collides with trap update");

    assert property (@(posedge clk) disable iff (!rst_n)
        state.mstatus[mstatus_mpp_hi:mstatus_mpp_lo] == 2'b11)
        else $error("csr_file: mstatus.MPP left machine mode");

endmodule

`default_nettype wire

//--- csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter logic [31:0] mtvec_reset = 32'h0
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire csr_bus_pkg::csr_req_t   req,
    output logic [31:0]                  rdata,
    output logic                         illegal,
    output csr_bus_pkg::redirect_t       redirect
);

    import csr_bus_pkg::*;

    csr_state_t state;                                         // Current register values
    csr_wr_t    wr;
    trap_wr_t   trap_wr;

    csr_access i_access (
        .req     (req),
        .state   (state),
        .wr      (wr),
        .rdata   (rdata),
        .illegal (illegal)
    );

    trap_ctrl i_trap (
        .req      (req),
        .state    (state),
        .trap_wr  (trap_wr),
        .redirect (redirect)
    );

    csr_file #(
        .mtvec_reset (mtvec_reset)
    ) i_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .trap_wr (trap_wr),
        .state   (state)
    );

endmodule

`default_nettype wire

//--- tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

    import csr_arch_pkg::*;
    import csr_bus_pkg::*;

    localparam logic [31:0] mtvec_init    = 32'h0000_0200;
    localparam logic [31:0] mie_mpie      = 32'h0000_0088;     // Writable mstatus bits
    localparam int          reset_cycles  = 16;
    localparam int          reset_timeout = 64;
    localparam int          num_random    = 3000;

    logic        clk;
    logic        rst_n;
    csr_req_t    req;
    logic [31:0] rdata;
    logic        illegal;
    redirect_t   redirect;

    logic [31:0] rng;
    logic [31:0] m_mstatus;                                    // Reference model
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    csr_unit #(
        .mtvec_reset (mtvec_init)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .rdata    (rdata),
        .illegal  (illegal),
        .redirect (redirect)
    );

    always #2 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    // **************************************************
    // Helpers
    // **************************************************

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic known_addr(input logic [11:0] addr);
        return (addr == addr_mstatus) || (addr == addr_mtvec)
            || (addr == addr_mepc) || (addr == addr_mcause);
    endfunction

    function automatic logic [31:0] model_value(input logic [11:0] addr);
        case (addr)
            addr_mstatus: return m_mstatus;
            addr_mtvec:   return m_mtvec;
            addr_mepc:    return m_mepc;
            addr_mcause:  return m_mcause;
            default:      return 32'h0;
        endcase
    endfunction

    task automatic write_model(input logic [11:0] addr, input logic [31:0] v);
        case (addr)
            addr_mstatus: m_mstatus = (m_mstatus & ~mie_mpie) | (v & mie_mpie);
            addr_mtvec:   m_mtvec   = v & ~32'h3;              // Aligned for direct mode
            addr_mepc:    m_mepc    = v & ~32'h3;
            default:      m_mcause  = v;
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // One request cycle drives, checks before the edge and advances the model
    task automatic do_request(input csr_op_e op, input logic [11:0] addr,
                              input logic [31:0] wdata, input logic [31:0] pc);
        logic        is_csr;
        logic        hit;
        logic [31:0] old_val;
        logic [31:0] new_val;
        @(posedge clk);
        #1;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        req.pc    = pc;
        is_csr  = (op == csr_rw) || (op == csr_rs) || (op == csr_rc);
        hit     = known_addr(addr);
        old_val = model_value(addr);
        #2;
        check_value("illegal", {31'h0, illegal}, {31'h0, is_csr && !hit});
        if (is_csr) begin
            check_value("rdata", rdata, hit ? old_val : 32'h0);
        end
        check_value("redirect.valid", {31'h0, redirect.valid},
                    {31'h0, (op == csr_ecall) || (op == csr_mret)});
        if (op == csr_ecall) begin
            check_value("redirect.target", redirect.target, m_mtvec);
        end
        if (op == csr_mret) begin
            check_value("redirect.target", redirect.target, m_mepc);
        end
        case (op)
            csr_rw, csr_rs, csr_rc: begin
                if (hit) begin
                    if (op == csr_rw) new_val = wdata;
                    else if (op == csr_rs) new_val = old_val | wdata;
                    else new_val = old_val & ~wdata;
                    write_model(addr, new_val);
                end
            end
            csr_ecall: begin
                m_mepc       = pc & ~32'h3;
                m_mcause     = 32'd11;
                m_mstatus[7] = m_mstatus[3];                   // MPIE takes MIE
                m_mstatus[3] = 1'b0;
            end
            csr_mret: begin
                m_mstatus[3] = m_mstatus[7];
                m_mstatus[7] = 1'b1;
            end
            default: ;
        endcase
    endtask

    // **************************************************
    // Stimulus
    // **************************************************

    initial begin
        int          waited;
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;
        logic [31:0] pc;
        clk       = 1'b0;
        req       = '0;
        req.op    = csr_none;
        rng       = 32'h55e6;
        m_mstatus = 32'h0000_1800;
        m_mtvec   = mtvec_init;
        m_mepc    = 32'h0;
        m_mcause  = 32'h0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > reset_timeout) begin
                $display("Timeout: reset was not released within %0d cycles", reset_timeout);
                $display("*** FAILED ***");
                $fatal(1, "Reset release timeout");
            end
        end

        do_request(csr_rs, addr_mstatus, 32'h0, 32'h0);        // Reset values
        do_request(csr_rs, addr_mtvec, 32'h0, 32'h0);
        do_request(csr_rs, addr_mepc, 32'h0, 32'h0);
        do_request(csr_rs, addr_mcause, 32'h0, 32'h0);
        do_request(csr_rw, addr_mstatus, 32'hffff_ffff, 32'h0);
        do_request(csr_rc, addr_mstatus, 32'h0000_0008, 32'h0);
        do_request(csr_rw, addr_mtvec, 32'h1234_5677, 32'h0);
        do_request(csr_rs, addr_mepc, 32'h8000_0003, 32'h0);
        do_request(csr_rw, addr_mcause, 32'hdead_beef, 32'h0);
        do_request(csr_rs, addr_mstatus, 32'h0, 32'h0);
        do_request(csr_ecall, 12'h0, 32'h0, 32'h0000_4006);
        do_request(csr_rs, addr_mepc, 32'h0, 32'h0);
        do_request(csr_rs, addr_mcause, 32'h0, 32'h0);
        do_request(csr_mret, 12'h0, 32'h0, 32'h0);
        do_request(csr_rs, addr_mstatus, 32'h0, 32'h0);
        do_request(csr_rw, 12'h7c0, 32'hffff_ffff, 32'h0);     // Unknown CSR
        do_request(csr_none, 12'h300, 32'h0, 32'h0);

        for (int n = 0; n < num_random; n++) begin
            rng = xorshift(rng);
            case (rng[3:0])
                4'd0, 4'd1:        op = csr_none;
                4'd2, 4'd3, 4'd4:  op = csr_rw;
                4'd5, 4'd6, 4'd7:  op = csr_rs;
                4'd8, 4'd9, 4'd10: op = csr_rc;
                4'd11, 4'd12:      op = csr_ecall;
                4'd13, 4'd14:      op = csr_mret;
                default:           op = csr_none;
            endcase
            if (rng[6:4] == 3'd0) begin
                addr = rng[27:16];                             // Mostly unknown
            end else begin
                case (rng[9:8])
                    2'd0:    addr = addr_mstatus;
                    2'd1:    addr = addr_mtvec;
                    2'd2:    addr = addr_mepc;
                    default: addr = addr_mcause;
                endcase
            end
            rng   = xorshift(rng);
            wdata = (rng[31:29] == 3'd0) ? 32'h0 : rng;
            rng   = xorshift(rng);
            pc    = rng;
            do_request(op, addr, wdata, pc);
        end

        @(posedge clk);
        #1;
        req.op = csr_none;
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
csr_arch_pkg.sv
csr_bus_pkg.sv
csr_access.sv
trap_ctrl.sv
csr_file.sv
csr_unit.sv
tb_csr_unit.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_csr_unit
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
